//--- hw/lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;

    // isa encodings, bits 15:12.
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass // b straight through.
    } lc3b_aluop;

    typedef struct packed {
        lc3b_aluop aluop;
        logic      use_imm;
        logic      regfile_load;
        logic      set_cc;
        logic      is_br;
        logic      is_jmp;
        logic      uses_sr1;
        logic      uses_sr2;
        lc3b_reg   dest;
    } lc3b_control_word;

    typedef enum logic {
        fwd_none, // id/ex value.
        fwd_wb    // ex/wb result.
    } lc3b_fwd_sel;

    localparam lc3b_word reset_pc = 16'h0000;
    localparam lc3b_word nop_ir = 16'h0000;  // br with empty mask.
    localparam lc3b_nzp reset_cc = 3'b010;

endpackage : lc3b_types

//--- hw/pipe_ctrl_if.sv
interface pipe_ctrl_if;

    logic                    flush;       // clears if/id and id/ex.
    logic                    redirect;
    lc3b_types::lc3b_word    redirect_pc;
    lc3b_types::lc3b_fwd_sel fwd_a_sel;
    lc3b_types::lc3b_fwd_sel fwd_b_sel;

    modport hazard (
        output flush,
        output redirect,
        output redirect_pc,
        output fwd_a_sel,
        output fwd_b_sel
    );

    modport stage (
        input flush,
        input redirect,
        input redirect_pc,
        input fwd_a_sel,
        input fwd_b_sel
    );

endinterface : pipe_ctrl_if

//--- hw/regwrite_if.sv
interface regwrite_if;

    logic                 load;  // ex/wb valid and regfile_load.
    lc3b_types::lc3b_reg  dest;
    lc3b_types::lc3b_word data;

    modport source (
        output load,
        output dest,
        output data
    );

    modport sink (
        input load,
        input dest,
        input data
    );

    modport monitor (
        input load,
        input dest
    );

endinterface : regwrite_if

//--- hw/stage_if.sv
module stage_if (
    input  logic                 clk,
    input  logic                 rst_n,

    output lc3b_types::lc3b_word imem_addr,
    input  lc3b_types::lc3b_word imem_data,
    input  logic                 imem_ready,

    pipe_ctrl_if.stage           ctrl,

    output lc3b_types::lc3b_word ir,
    output lc3b_types::lc3b_word pc,
    output logic                 valid
);

    lc3b_types::lc3b_word fetch_pc;
    lc3b_types::lc3b_word pc_plus2;

    assign imem_addr = fetch_pc;
    assign pc_plus2 = fetch_pc + 16'd2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pc <= lc3b_types::reset_pc;
        end else if (ctrl.redirect) begin
            fetch_pc <= ctrl.redirect_pc;
        end else if (imem_ready) begin
            fetch_pc <= pc_plus2;
        end
    end

    // if/id barrier takes a bubble whenever nothing was fetched.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
            ir <= lc3b_types::nop_ir;
        end else if (ctrl.flush || ctrl.redirect || !imem_ready) begin
            valid <= 1'b0;
            ir <= lc3b_types::nop_ir;
        end else begin
            valid <= 1'b1;
            ir <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        pc <= pc_plus2; // pc of the next instruction.
    end

    // jmp and branch targets must keep fetch word aligned.
    pc_even_check: assert property (
        @(posedge clk) disable iff (!rst_n) !fetch_pc[0]
    );

endmodule : stage_if

//--- hw/stage_id.sv
module stage_id (
    input  logic                         clk,
    input  logic                         rst_n,

    input  lc3b_types::lc3b_word         ir_in,
    input  lc3b_types::lc3b_word         pc_in,
    input  logic                         valid_in,

    pipe_ctrl_if.stage                   ctrl,
    regwrite_if.sink                     wr,

    output lc3b_types::lc3b_control_word control,
    output lc3b_types::lc3b_reg          sr1,
    output lc3b_types::lc3b_reg          sr2,
    output lc3b_types::lc3b_word         sr1_val,
    output lc3b_types::lc3b_word         sr2_val,
    output lc3b_types::lc3b_word         imm,
    output lc3b_types::lc3b_word         pc,
    output lc3b_types::lc3b_word         ir,
    output logic                         valid
);

    lc3b_types::lc3b_word         regs [0:7];
    lc3b_types::lc3b_opcode       opcode;
    lc3b_types::lc3b_control_word dec_control;
    lc3b_types::lc3b_reg          dec_sr1;
    lc3b_types::lc3b_reg          dec_sr2;
    lc3b_types::lc3b_word         dec_imm;
    lc3b_types::lc3b_word         imm5_sext;
    lc3b_types::lc3b_word         off9_shifted;

    assign opcode = lc3b_types::lc3b_opcode'(ir_in[15:12]);
    assign dec_sr1 = ir_in[8:6];  // also the jmp base.
    assign dec_sr2 = ir_in[2:0];
    assign imm5_sext = {{11{ir_in[4]}}, ir_in[4:0]};
    assign off9_shifted = {{6{ir_in[8]}}, ir_in[8:0], 1'b0};

    always_comb begin
        dec_control = '0;
        dec_control.aluop = lc3b_types::alu_pass;
        dec_control.dest = ir_in[11:9];
        dec_imm = imm5_sext;
        case (opcode)
            lc3b_types::op_add, lc3b_types::op_and: begin
                dec_control.aluop = (opcode == lc3b_types::op_add) ?
                                    lc3b_types::alu_add : lc3b_types::alu_and;
                dec_control.use_imm = ir_in[5];
                dec_control.regfile_load = 1'b1;
                dec_control.set_cc = 1'b1;
                dec_control.uses_sr1 = 1'b1;
                dec_control.uses_sr2 = !ir_in[5];
            end
            lc3b_types::op_not: begin
                dec_control.aluop = lc3b_types::alu_not;
                dec_control.regfile_load = 1'b1;
                dec_control.set_cc = 1'b1;
                dec_control.uses_sr1 = 1'b1;
            end
            lc3b_types::op_lea: begin
                dec_control.use_imm = 1'b1;
                dec_control.regfile_load = 1'b1; // cc left alone.
                dec_imm = pc_in + off9_shifted;
            end
            lc3b_types::op_br: begin
                dec_control.is_br = 1'b1;
                dec_imm = off9_shifted;
            end
            lc3b_types::op_jmp: begin
                dec_control.is_jmp = 1'b1;
                dec_control.uses_sr1 = 1'b1;
            end
            default: ; // retires as a no-op.
        endcase
    end

    // retiring write is seen by the read in the same cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wr.load) begin
            regs[wr.dest] <= wr.data;
        end
    end

    // id/ex barrier.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
            control <= '0;
        end else begin
            valid <= valid_in && !ctrl.flush;
            control <= dec_control;
        end
    end

    always_ff @(posedge clk) begin
        sr1 <= dec_sr1;
        sr2 <= dec_sr2;
        sr1_val <= (wr.load && wr.dest == dec_sr1) ? wr.data : regs[dec_sr1];
        sr2_val <= (wr.load && wr.dest == dec_sr2) ? wr.data : regs[dec_sr2];
        imm <= dec_imm;
        pc <= pc_in;
        ir <= ir_in;
    end

    br_no_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid && control.is_br |-> !control.regfile_load
    );

endmodule : stage_id

//--- hw/stage_ex.sv
module stage_ex (
    input  logic                         clk,
    input  logic                         rst_n,

    input  lc3b_types::lc3b_control_word control,
    input  lc3b_types::lc3b_word         sr1_val,
    input  lc3b_types::lc3b_word         sr2_val,
    input  lc3b_types::lc3b_word         imm,
    input  lc3b_types::lc3b_word         pc,
    input  lc3b_types::lc3b_word         ir,
    input  logic                         valid,

    pipe_ctrl_if.stage                   ctrl,
    regwrite_if.source                   wr,

    output logic                         taken,
    output lc3b_types::lc3b_word         target
);

    lc3b_types::lc3b_word op_a;
    lc3b_types::lc3b_word op_b_reg;
    lc3b_types::lc3b_word op_b;
    lc3b_types::lc3b_word alu_out;
    lc3b_types::lc3b_nzp  alu_nzp;
    lc3b_types::lc3b_nzp  cc;
    logic                 br_hit;

    logic                 wb_valid;
    logic                 wb_regfile_load;
    lc3b_types::lc3b_reg  wb_dest;
    lc3b_types::lc3b_word wb_data;

    // forwarding from the ex/wb barrier.
    assign op_a = (ctrl.fwd_a_sel == lc3b_types::fwd_wb) ? wb_data : sr1_val;
    assign op_b_reg = (ctrl.fwd_b_sel == lc3b_types::fwd_wb) ? wb_data : sr2_val;
    assign op_b = control.use_imm ? imm : op_b_reg;

    always_comb begin
        case (control.aluop)
            lc3b_types::alu_add: alu_out = op_a + op_b;
            lc3b_types::alu_and: alu_out = op_a & op_b;
            lc3b_types::alu_not: alu_out = ~op_a;
            default:             alu_out = op_b;
        endcase
    end

    assign alu_nzp = {alu_out[15], alu_out == 16'h0000,
                      !alu_out[15] && alu_out != 16'h0000};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc <= lc3b_types::reset_cc;
        end else if (valid && control.set_cc) begin
            cc <= alu_nzp;
        end
    end

    // br mask sits in ir[11:9].
    assign br_hit = control.is_br && ((ir[11:9] & cc) != 3'b000);
    assign taken = valid && (br_hit || control.is_jmp);
    assign target = control.is_jmp ? op_a : pc + imm;

    // ex/wb barrier.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_regfile_load <= 1'b0;
        end else begin
            wb_valid <= valid;
            wb_regfile_load <= control.regfile_load;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest <= control.dest;
        wb_data <= alu_out;
    end

    assign wr.load = wb_valid && wb_regfile_load;
    assign wr.dest = wb_dest;
    assign wr.data = wb_data;

    // a redirect needs a live item, and the flush kills the next one.
    taken_flushes: assert property (
        @(posedge clk) disable iff (!rst_n)
        taken |-> valid ##1 !valid
    );

endmodule : stage_ex

//--- hw/hazard_unit.sv
module hazard_unit (
    input  lc3b_types::lc3b_control_word control,
    input  lc3b_types::lc3b_reg          sr1,
    input  lc3b_types::lc3b_reg          sr2,
    input  logic                         valid,

    regwrite_if.monitor                  wr,

    input  logic                         taken,
    input  lc3b_types::lc3b_word         target,

    pipe_ctrl_if.hazard                  ctrl
);

    logic hit_a;
    logic hit_b;

    // only the ex/wb result can be newer than the id/ex operands.
    assign hit_a = valid && control.uses_sr1 && wr.load && (wr.dest == sr1);
    assign hit_b = valid && control.uses_sr2 && wr.load && (wr.dest == sr2);

    always_comb begin
        ctrl.fwd_a_sel = lc3b_types::fwd_none;
        ctrl.fwd_b_sel = lc3b_types::fwd_none;
        if (hit_a) begin
            ctrl.fwd_a_sel = lc3b_types::fwd_wb;
        end
        if (hit_b) begin
            ctrl.fwd_b_sel = lc3b_types::fwd_wb;
        end
    end

    // not-taken prediction, so any taken item redirects.
    assign ctrl.flush = taken;
    assign ctrl.redirect = taken;
    assign ctrl.redirect_pc = target;

endmodule : hazard_unit

//--- hw/cpu.sv
module cpu (
    input  logic                 clk,
    input  logic                 rst_n,

    output lc3b_types::lc3b_word imem_addr,
    input  lc3b_types::lc3b_word imem_data,
    input  logic                 imem_ready,

    output logic                 wb_load,
    output lc3b_types::lc3b_reg  wb_dest,
    output lc3b_types::lc3b_word wb_data
);

    pipe_ctrl_if ctrl_bus ();
    regwrite_if  wr_bus ();

    // if/id.
    lc3b_types::lc3b_word         if_id_ir;
    lc3b_types::lc3b_word         if_id_pc;
    logic                         if_id_valid;

    // id/ex.
    lc3b_types::lc3b_control_word id_ex_control;
    lc3b_types::lc3b_reg          id_ex_sr1;
    lc3b_types::lc3b_reg          id_ex_sr2;
    lc3b_types::lc3b_word         id_ex_sr1_val;
    lc3b_types::lc3b_word         id_ex_sr2_val;
    lc3b_types::lc3b_word         id_ex_imm;
    lc3b_types::lc3b_word         id_ex_pc;
    lc3b_types::lc3b_word         id_ex_ir;
    logic                         id_ex_valid;

    logic                         ex_taken;
    lc3b_types::lc3b_word         ex_target;

    stage_if _stage_if (
        .clk,
        .rst_n,
        .imem_addr,
        .imem_data,
        .imem_ready,
        .ctrl(ctrl_bus),
        .ir(if_id_ir),
        .pc(if_id_pc),
        .valid(if_id_valid)
    );

    stage_id _stage_id (
        .clk,
        .rst_n,
        .ir_in(if_id_ir),
        .pc_in(if_id_pc),
        .valid_in(if_id_valid),
        .ctrl(ctrl_bus),
        .wr(wr_bus),
        .control(id_ex_control),
        .sr1(id_ex_sr1),
        .sr2(id_ex_sr2),
        .sr1_val(id_ex_sr1_val),
        .sr2_val(id_ex_sr2_val),
        .imm(id_ex_imm),
        .pc(id_ex_pc),
        .ir(id_ex_ir),
        .valid(id_ex_valid)
    );

    stage_ex _stage_ex (
        .clk,
        .rst_n,
        .control(id_ex_control),
        .sr1_val(id_ex_sr1_val),
        .sr2_val(id_ex_sr2_val),
        .imm(id_ex_imm),
        .pc(id_ex_pc),
        .ir(id_ex_ir),
        .valid(id_ex_valid),
        .ctrl(ctrl_bus),
        .wr(wr_bus),
        .taken(ex_taken),
        .target(ex_target)
    );

    hazard_unit _hazard_unit (
        .control(id_ex_control),
        .sr1(id_ex_sr1),
        .sr2(id_ex_sr2),
        .valid(id_ex_valid),
        .wr(wr_bus),
        .taken(ex_taken),
        .target(ex_target),
        .ctrl(ctrl_bus)
    );

    assign wb_load = wr_bus.load;  // retired writes.
    assign wb_dest = wr_bus.dest;
    assign wb_data = wr_bus.data;

endmodule : cpu

//--- dv/cpu_tb.sv
module cpu_tb;

    logic                 clk;
    logic                 rst_n;
    lc3b_types::lc3b_word imem_addr;
    lc3b_types::lc3b_word imem_data;
    logic                 imem_ready;
    logic                 wb_load;
    lc3b_types::lc3b_reg  wb_dest;
    lc3b_types::lc3b_word wb_data;

    lc3b_types::lc3b_word tests_mem [0:255]; // P, program, E, dest/data pairs.
    int prog_len;
    int exp_count;
    int checked = 0;
    int cycles = 0;
    int limit = 0;
    int seed;

    cpu uut (
        .clk(clk),
        .rst_n(rst_n),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .imem_ready(imem_ready),
        .wb_load(wb_load),
        .wb_dest(wb_dest),
        .wb_data(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic lc3b_types::lc3b_word fetch_word(input lc3b_types::lc3b_word addr);
        int idx;
        idx = int'(addr[15:1]);
        if (idx < prog_len) begin
            return tests_mem[1 + idx];
        end
        return lc3b_types::nop_ir; // past the end of the program.
    endfunction

    task automatic check_reg(input string name, input lc3b_types::lc3b_reg got,
                             input lc3b_types::lc3b_reg expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s = %0d, expected %0d", $time, name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "write-back destination wrong");
        end
    endtask

    task automatic check_word(input string name, input lc3b_types::lc3b_word got,
                              input lc3b_types::lc3b_word expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, expected);
            $display("STATUS: FAIL");
            $fatal(1, "write-back data wrong");
        end
    endtask

    // memory model and random ready pattern.
    always @(negedge clk) begin
        imem_ready = ($random(seed) % 4) != 0;
        imem_data = fetch_word(imem_addr);
    end

    // retired writes against the expected list.
    always @(negedge clk) begin
        if (wb_load === 1'b1) begin
            if (checked >= exp_count) begin
                $display("unexpected register write r%0d = %h after all %0d expected writes",
                         wb_dest, wb_data, exp_count);
                $display("STATUS: FAIL");
                $fatal(1, "extra register write");
            end else begin
                check_reg("wb_dest", wb_dest, tests_mem[prog_len + 2 + 2 * checked][2:0]);
                check_word("wb_data", wb_data, tests_mem[prog_len + 3 + 2 * checked]);
                checked = checked + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, %0d of %0d writes seen",
                     cycles, checked, exp_count);
            $display("STATUS: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        seed = 10;
        rst_n = 1'b0;
        imem_ready = 1'b0;
        imem_data = lc3b_types::nop_ir;
        $readmemh("dv/cpu_tests.txt", tests_mem);
        prog_len = int'(tests_mem[0]);
        exp_count = int'(tests_mem[prog_len + 1]);
        limit = 8 * (prog_len + exp_count) + 40; // generous for bubbles and flushes.
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wait (checked == exp_count);
        repeat (20) @(posedge clk); // the self-loop must stay silent.
        $display("STATUS: PASS");
        $finish;
    end

endmodule : cpu_tb

//--- dv/cpu_tests.txt
// program length P, then P instruction words (hex)
// write count E, then E lines of dest register and data
0014
1225 // add r1, r0, #5
1463 // add r2, r1, #3
1642 // add r3, r1, r2
58FC // and r4, r3, #-4
9B3F // not r5, r4
5D43 // and r6, r5, r3
0801 // brn +1, not taken
1FBF // add r7, r6, #-1
0402 // brz +2, taken
1261 // add r1, r1, #1, flushed
14A1 // add r2, r2, #1, flushed
E204 // lea r1, +4
0401 // brz +1, taken on old cc
16E1 // add r3, r3, #1, flushed
C040 // jmp r1
1421 // add r2, r0, #1, skipped
947F // not r2, r1
0202 // brp +2, not taken
1681 // add r3, r2, r1
0FFF // br to self
000A
1 0005
2 0008
3 000D
4 000C
5 FFF3
6 0001
7 0000
1 0020
2 FFDF
3 FFFF

//--- src.f
hw/lc3b_types.sv
hw/pipe_ctrl_if.sv
hw/regwrite_if.sv
hw/stage_if.sv
hw/stage_id.sv
hw/stage_ex.sv
hw/hazard_unit.sv
hw/cpu.sv
dv/cpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -Mdir obj_dir -f src.f

out=$(./obj_dir/Vcpu_tb || true)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS"
